/* tb.f */
hdl/com_pkg.sv
hdl/cache_pkg.sv
hdl/com_crc5.sv
hdl/com_rx.sv
hdl/pkt_dispatch.sv
hdl/cache_arbiter.sv
hdl/param_cache.sv
hdl/com_subsys.sv
testbench/com_subsys_assertions.sv
testbench/tb_com_subsys.sv

/* testbench/tb_com_subsys.sv */
`default_nettype none

module tb_com_subsys
    import com_pkg::*;
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          clk_period    = 40;
    localparam int          num_packets   = 300;
    localparam int          max_pkt_bytes = 28;
    localparam int          read_timeout  = 20;
    localparam int          watchdog_ns   = (num_packets * max_pkt_bytes + 2000) * clk_period;
    localparam logic [31:0] rand_seed     = 32'h90b99e3a;

    logic         clk;
    logic         rst;
    logic [7:0]   com_rxd;
    logic         rd_req;
    logic [3:0]   rd_addr;
    cache_entry_t rd_data;
    logic         rd_valid;
    logic [3:0]   cur_device;
    logic [3:0]   cur_data_idx;
    pkt_stats_t   stats;

    // Reference model state
    cache_entry_t mirror [cache_depth];
    pkt_stats_t   m_stats;
    logic [3:0]   m_device;
    logic [3:0]   m_data_idx;
    longint       cyc = 0;
    longint       commit_cyc = 0;
    logic [3:0]   commit_addr;
    cache_entry_t commit_entry;

    int   errors;
    int   checks;
    int   reads_issued;
    int   valid_cnt = 0;
    int   tests_run;
    int   tests_failed;
    logic stream_done;

    com_subsys com_subsys_i (
        .clk          (clk),
        .rst          (rst),
        .com_rxd      (com_rxd),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .cur_device   (cur_device),
        .cur_data_idx (cur_data_idx),
        .stats        (stats)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    // A parameter write lands in the cache on the third clock after its check byte
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst) begin
            for (int i = 0; i < cache_depth; i++) begin
                mirror[i] = '0;
            end
        end else if (cyc == commit_cyc) begin
            mirror[commit_addr] = commit_entry;
        end
    end

    always @(negedge clk) begin
        if (rd_valid) valid_cnt++;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    // x^5+x^2+1 over one byte, least significant bit first
    function automatic logic [4:0] crc5_byte(input logic [4:0] c, input logic [7:0] b);
        logic [4:0] r;
        logic       msb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            msb = r[4];
            r = r << 1;
            if (msb != b[i]) r = r ^ 5'h05;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_model_state();
        check_value("stats.ack_cnt", stats.ack_cnt, m_stats.ack_cnt);
        check_value("stats.nak_cnt", stats.nak_cnt, m_stats.nak_cnt);
        check_value("stats.stl_cnt", stats.stl_cnt, m_stats.stl_cnt);
        check_value("stats.link_cnt", stats.link_cnt, m_stats.link_cnt);
        check_value("stats.err_cnt", stats.err_cnt, m_stats.err_cnt);
        check_value("cur_device", cur_device, m_device);
        check_value("cur_data_idx", cur_data_idx, m_data_idx);
    endtask

    task automatic host_read(input logic [3:0] addr);
        int   waited;
        logic seen;
        @(negedge clk);
        rd_addr = addr;
        rd_req = 1'b1;
        reads_issued++;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < read_timeout) begin
            @(negedge clk);
            waited++;
            if (rd_valid) seen = 1'b1;
        end
        if (seen) begin
            check_value($sformatf("rd_data[%0d]", addr), rd_data, mirror[addr]);
        end else begin
            errors++;
            $display("Read of cache address %0d never returned rd_valid", addr);
        end
        rd_req = 1'b0;
    endtask

    task automatic send_packet();
        logic [7:0]   pkt [$];
        int           kind;
        int           len;
        logic [7:0]   b;
        logic [3:0]   head;
        logic [3:0]   nib;
        logic [4:0]   crc;
        logic [7:0]   chk;
        logic         bad;
        logic         is_write;
        cache_entry_t ent;
        kind = $urandom % 12;
        is_write = 1'b0;
        pkt.push_back(pid_sync);
        if (kind == 0) begin
            pkt.push_back(pid_ack);
            m_stats.ack_cnt = m_stats.ack_cnt + 8'd1;
        end else if (kind == 1) begin
            pkt.push_back(pid_nak);
            m_stats.nak_cnt = m_stats.nak_cnt + 8'd1;
        end else if (kind == 2) begin
            pkt.push_back(pid_stl);
            m_stats.stl_cnt = m_stats.stl_cnt + 8'd1;
        end else if (kind == 3) begin
            b = rand_byte();
            while (b == pid_cmd || b == pid_ack || b == pid_nak || b == pid_stl) begin
                b = rand_byte();
            end
            pkt.push_back(b);
            m_stats.err_cnt = m_stats.err_cnt + 8'd1;
        end else begin
            if (kind < 6) begin
                head = head_didx;
            end else if (kind < 8) begin
                head = head_ddidx;
            end else if (kind < 11) begin
                head = head_dparam;
            end else begin
                head = 4'($urandom % 16);
                while (head == head_didx || head == head_ddidx || head == head_dparam) begin
                    head = 4'($urandom % 16);
                end
            end
            len = $urandom_range(1, 15);
            nib = 4'($urandom % 16);
            pkt.push_back(pid_cmd);
            pkt.push_back(rand_byte());
            b = rand_byte();
            b[3:0] = 4'(len);
            pkt.push_back(b);
            crc = crc5_byte(crc_init, b);
            ent = '0;
            ent.sample_rate = nib;
            for (int i = 0; i < len; i++) begin
                if (i == 0) b = {head, nib};
                else b = rand_byte();
                if (i == 1) begin
                    ent.filt_up = b[7:4];
                    ent.filt_low = b[3:0];
                end
                pkt.push_back(b);
                crc = crc5_byte(crc, b);
            end
            chk = {3'b000, crc};
            bad = ($urandom % 8) == 0;
            if (bad) chk = chk ^ (8'd1 + 8'($urandom % 255));
            pkt.push_back(chk);
            if (bad) m_stats.err_cnt = m_stats.err_cnt + 8'd1;
            else if (head == head_didx) m_device = nib;
            else if (head == head_ddidx) m_data_idx = nib;
            else if (head == head_dparam) is_write = 1'b1;
            else m_stats.link_cnt = m_stats.link_cnt + 8'd1;
        end
        foreach (pkt[i]) begin
            @(negedge clk);
            com_rxd = pkt[i];
            if (i == pkt.size() - 1 && is_write) begin
                commit_addr = m_device;
                commit_entry = ent;
                commit_cyc = cyc + 3;
            end
        end
    endtask

    task automatic send_gap();
        int n;
        n = $urandom_range(4, 8);
        repeat (n) begin
            @(negedge clk);
            com_rxd = 8'h00;
        end
    endtask

    task automatic run_host_reads();
        while (!stream_done) begin
            repeat ($urandom_range(2, 40)) @(negedge clk);
            if (!stream_done) host_read(4'($urandom % cache_depth));
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - err_before);
        end else begin
            $display("Test %s passed", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int err_before;
        void'($urandom(rand_seed));
        rst = 1'b1;
        com_rxd = 8'h00;
        rd_req = 1'b0;
        rd_addr = 4'd0;
        m_stats = '0;
        m_device = 4'd0;
        m_data_idx = 4'd0;
        errors = 0;
        checks = 0;
        reads_issued = 0;
        tests_run = 0;
        tests_failed = 0;
        stream_done = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err_before = errors;
        check_model_state();
        for (int a = 0; a < cache_depth; a++) begin
            host_read(4'(a));
        end
        finish_test("reset_state", err_before);

        err_before = errors;
        fork
            begin
                for (int p = 0; p < num_packets; p++) begin
                    send_packet();
                    send_gap();
                    check_model_state();
                end
                stream_done = 1'b1;
            end
            run_host_reads();
        join
        finish_test("packet_stream", err_before);

        err_before = errors;
        repeat (4) @(negedge clk);
        for (int a = 0; a < cache_depth; a++) begin
            host_read(4'(a));
        end
        repeat (2) @(negedge clk);
        check_value("rd_valid pulses", valid_cnt, reads_issued);
        check_value("assertion failures", com_subsys_i.com_subsys_assertions_i.fail_cnt, 0);
        finish_test("final_sweep", err_before);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d reads",
                 tests_run, tests_failed, checks, errors, reads_issued);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/com_subsys_assertions.sv */
`default_nettype none

module com_subsys_assertions
    import com_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       done,
    input logic       ack,
    input pkt_class_t cls,
    input logic       wr_req,
    input logic       wr_gnt
);

    timeunit 1ns;
    timeprecision 100ps;

    int done_fails = 0;
    int ack_fails = 0;
    int gnt_fails = 0;
    int fail_cnt;

    assign fail_cnt = done_fails + ack_fails + gnt_fails;

    // A finished packet keeps done and its class until the dispatcher takes it
    done_held: assert property (@(posedge clk) disable iff (rst)
        done && !ack |=> done && $stable(cls))
        else begin
            $error("done dropped or cls changed before ack");
            done_fails++;
        end

    ack_in_done: assert property (@(posedge clk) disable iff (rst) ack |-> done)
        else begin
            $error("ack raised while done is low");
            ack_fails++;
        end

    // A granted write completes at once and the request drops on the next cycle
    gnt_with_req: assert property (@(posedge clk) disable iff (rst)
        wr_gnt |-> wr_req ##1 !wr_req)
        else begin
            $error("wr_gnt without wr_req, or wr_req held past its grant");
            gnt_fails++;
        end

endmodule

bind com_subsys com_subsys_assertions com_subsys_assertions_i (
    .clk    (clk),
    .rst    (rst),
    .done   (done),
    .ack    (ack),
    .cls    (cls),
    .wr_req (wr_req),
    .wr_gnt (wr_gnt)
);

`default_nettype wire

/* hdl/com_subsys.sv */
`default_nettype none

module com_subsys
    import com_pkg::*;
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          com_rxd,
    input  logic                rd_req,
    input  logic [cache_aw-1:0] rd_addr,
    output cache_entry_t        rd_data,
    output logic                rd_valid,
    output logic [3:0]          cur_device,
    output logic [3:0]          cur_data_idx,
    output pkt_stats_t          stats
);

    logic                done;
    logic                ack;
    pkt_class_t          cls;
    cmd_fields_t         fields;
    logic                wr_req;
    logic                wr_gnt;
    cache_wr_t           wr_data;
    logic                mem_we;
    logic                mem_re;
    logic [cache_aw-1:0] mem_addr;
    cache_entry_t        mem_wdata;

    ////////////////////////////////////////////////////////////
    // Receive side
    ////////////////////////////////////////////////////////////

    com_rx com_rx_i (
        .clk     (clk),
        .rst     (rst),
        .com_rxd (com_rxd),
        .done    (done),
        .ack     (ack),
        .cls     (cls),
        .fields  (fields)
    );

    pkt_dispatch pkt_dispatch_i (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .cls          (cls),
        .fields       (fields),
        .ack          (ack),
        .wr_req       (wr_req),
        .wr_data      (wr_data),
        .wr_gnt       (wr_gnt),
        .cur_device   (cur_device),
        .cur_data_idx (cur_data_idx),
        .stats        (stats)
    );

    ////////////////////////////////////////////////////////////
    // Parameter cache
    ////////////////////////////////////////////////////////////

    // The host learns of completion through rd_valid, so rd_gnt stays inside
    cache_arbiter cache_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .wr_gnt    (wr_gnt),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_gnt    (),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_re    (mem_re)
    );

    param_cache param_cache_i (
        .clk       (clk),
        .rst       (rst),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_re    (mem_re),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

endmodule

`default_nettype wire

/* hdl/param_cache.sv */
`default_nettype none

module param_cache
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_we,
    input  logic [cache_aw-1:0] mem_addr,
    input  cache_entry_t        mem_wdata,
    input  logic                mem_re,
    output cache_entry_t        rd_data,
    output logic                rd_valid
);

    cache_entry_t mem [cache_depth];

    // Entries start out zero so an unwritten device reads back empty
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cache_depth; i++) begin
                mem[i] <= '0;
            end
            rd_valid <= 1'b0;
        end else begin
            if (mem_we) mem[mem_addr] <= mem_wdata;
            rd_valid <= mem_re;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_re) rd_data <= mem[mem_addr];
    end

endmodule

`default_nettype wire

/* hdl/cache_arbiter.sv */
`default_nettype none

module cache_arbiter
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_req,
    input  cache_wr_t           wr_data,
    output logic                wr_gnt,
    input  logic                rd_req,
    input  logic [cache_aw-1:0] rd_addr,
    output logic                rd_gnt,
    output logic                mem_we,
    output logic [cache_aw-1:0] mem_addr,
    output cache_entry_t        mem_wdata,
    output logic                mem_re
);

    // Writes always win, a read only goes through in a cycle without one
    assign wr_gnt = wr_req;
    assign mem_we = wr_gnt;
    assign mem_re = rd_req && !wr_req && !rd_gnt;

    assign mem_addr  = wr_gnt ? wr_data.addr : rd_addr;
    assign mem_wdata = wr_data.entry;

    // Held high from the cycle after the access until the host lets go of
    // rd_req, so one request maps to exactly one cache read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_gnt <= 1'b0;
        end else if (mem_re) begin
            rd_gnt <= 1'b1;
        end else if (!rd_req) begin
            rd_gnt <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/pkt_dispatch.sv */
`default_nettype none

module pkt_dispatch
    import com_pkg::*;
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        done,
    input  pkt_class_t  cls,
    input  cmd_fields_t fields,
    output logic        ack,
    output logic        wr_req,
    output cache_wr_t   wr_data,
    input  logic        wr_gnt,
    output logic [3:0]  cur_device,
    output logic [3:0]  cur_data_idx,
    output pkt_stats_t  stats
);

    logic ack_q;
    logic start;

    // A waiting packet is taken once, then ignored until the parser drops done
    assign start = done && !ack && !wr_req;

    // Parameter packets are acknowledged by the cache grant itself
    assign ack = ack_q || (wr_req && wr_gnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
            wr_req <= 1'b0;
            cur_device <= 4'd0;
            cur_data_idx <= 4'd0;
            stats <= '0;
        end else begin
            ack_q <= start && (cls != cls_dparam);

            if (wr_gnt) wr_req <= 1'b0;
            else if (start && cls == cls_dparam) wr_req <= 1'b1;

            if (start) begin
                case (cls)
                    cls_didx:  cur_device <= fields.device_idx;
                    cls_ddidx: cur_data_idx <= fields.data_idx;
                    cls_ack:   stats.ack_cnt <= stats.ack_cnt + 8'd1;
                    cls_nak:   stats.nak_cnt <= stats.nak_cnt + 8'd1;
                    cls_stl:   stats.stl_cnt <= stats.stl_cnt + 8'd1;
                    cls_link:  stats.link_cnt <= stats.link_cnt + 8'd1;
                    cls_error: stats.err_cnt <= stats.err_cnt + 8'd1;
                    default: ;
                endcase
            end
        end
    end

    // Write target is the device selected when the packet arrives
    always_ff @(posedge clk) begin
        if (start && cls == cls_dparam) begin
            wr_data.addr <= cur_device;
            wr_data.entry <= cache_entry_t'{
                sample_rate: fields.sample_rate,
                filt_up:     fields.filt_up,
                filt_low:    fields.filt_low
            };
        end
    end

endmodule

`default_nettype wire

/* hdl/com_rx.sv */
`default_nettype none

module com_rx
    import com_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  com_rxd,
    output logic        done,
    input  logic        ack,
    output pkt_class_t  cls,
    output cmd_fields_t fields
);

    typedef enum logic [2:0] {
        st_wait,
        st_id,
        st_length,
        st_payload,
        st_check,
        st_error,
        st_done
    } state_t;

    state_t     state;
    state_t     next_state;
    logic [3:0] cnt;
    logic [3:0] pay_len;
    logic       crc_en;
    logic       crc_clr;
    logic [4:0] crc;

    assign done = (state == st_done);

    // The second length byte and every payload byte go into the CRC
    assign crc_clr = (state == st_wait);
    assign crc_en  = (state == st_payload) || (state == st_length && cnt == 4'd1);

    com_crc5 crc_i (
        .clk    (clk),
        .rst    (rst),
        .enable (crc_en),
        .clear  (crc_clr),
        .din    (com_rxd),
        .crc    (crc)
    );

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_wait: begin
                if (com_rxd == pid_sync) next_state = st_id;
            end
            st_id: begin
                if (com_rxd == pid_cmd) begin
                    next_state = st_length;
                end else if (com_rxd == pid_ack || com_rxd == pid_nak || com_rxd == pid_stl) begin
                    next_state = st_done;
                end else begin
                    next_state = st_error;
                end
            end
            st_length: begin
                // An empty payload goes straight to the check byte
                if (cnt == 4'd1 && com_rxd[3:0] == 4'd0) next_state = st_check;
                else if (cnt == 4'd1) next_state = st_payload;
            end
            st_payload: begin
                if (cnt == pay_len - 4'd1) next_state = st_check;
            end
            st_check: begin
                if (com_rxd[7:5] != 3'b000 || com_rxd[4:0] != crc) next_state = st_error;
                else next_state = st_done;
            end
            st_error: next_state = st_done;
            st_done: begin
                if (ack) next_state = st_wait;
            end
            default: next_state = st_wait;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_wait;
            cnt <= 4'd0;
            pay_len <= 4'd0;
        end else begin
            state <= next_state;
            if (state == st_length && cnt == 4'd0) cnt <= 4'd1;
            else if (state == st_payload) cnt <= cnt + 4'd1;
            else cnt <= 4'd0;
            if (state == st_length && cnt == 4'd1) pay_len <= com_rxd[3:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Class and field extraction
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cls <= cls_none;
            fields <= '0;
        end else begin
            case (state)
                st_wait: begin
                    cls <= cls_none;
                    fields <= '0;
                end
                st_id: begin
                    if (com_rxd == pid_ack) cls <= cls_ack;
                    else if (com_rxd == pid_nak) cls <= cls_nak;
                    else if (com_rxd == pid_stl) cls <= cls_stl;
                end
                st_payload: begin
                    if (cnt == 4'd0) begin
                        case (com_rxd[7:4])
                            head_didx: begin
                                cls <= cls_didx;
                                fields.device_idx <= com_rxd[3:0];
                            end
                            head_ddidx: begin
                                cls <= cls_ddidx;
                                fields.data_idx <= com_rxd[3:0];
                            end
                            head_dparam: begin
                                cls <= cls_dparam;
                                fields.sample_rate <= com_rxd[3:0];
                            end
                            default: cls <= cls_link;
                        endcase
                    end else if (cnt == 4'd1 && cls == cls_dparam) begin
                        fields.filt_up <= com_rxd[7:4];
                        fields.filt_low <= com_rxd[3:0];
                    end
                end
                st_error: cls <= cls_error;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/com_crc5.sv */
`default_nettype none

module com_crc5
    import com_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       clear,
    input  logic [7:0] din,
    output logic [4:0] crc
);

    logic [4:0] crc_next;
    logic       fb;

    // Serial LFSR for x^5+x^2+1 unrolled over one byte, bit 0 first
    always_comb begin
        crc_next = crc;
        fb = 1'b0;
        for (int i = 0; i < 8; i++) begin
            fb = crc_next[4] ^ din[i];
            crc_next = {crc_next[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= crc_init;
        end else if (clear) begin
            crc <= crc_init;
        end else if (enable) begin
            crc <= crc_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int cache_depth = 16;
    localparam int cache_aw    = $clog2(cache_depth);

    // One cached parameter set per device
    typedef struct packed {
        logic [3:0] sample_rate;
        logic [3:0] filt_up;
        logic [3:0] filt_low;
    } cache_entry_t;

    typedef struct packed {
        logic [cache_aw-1:0] addr;
        cache_entry_t        entry;
    } cache_wr_t;

    // Counters wrap at 255
    typedef struct packed {
        logic [7:0] ack_cnt;
        logic [7:0] nak_cnt;
        logic [7:0] stl_cnt;
        logic [7:0] link_cnt;
        logic [7:0] err_cnt;
    } pkt_stats_t;

endpackage

`default_nettype wire

/* hdl/com_pkg.sv */
`default_nettype none

package com_pkg;

    ////////////////////////////////////////////////////////////
    // Packet id bytes
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] pid_sync = 8'h01;
    localparam logic [7:0] pid_cmd  = 8'h1E;
    localparam logic [7:0] pid_ack  = 8'h2D;
    localparam logic [7:0] pid_nak  = 8'hA5;
    localparam logic [7:0] pid_stl  = 8'hE1;

    // Upper nibble of the first payload byte selects the command
    localparam logic [3:0] head_didx   = 4'h9;
    localparam logic [3:0] head_ddidx  = 4'h1;
    localparam logic [3:0] head_dparam = 4'h5;

    // CRC-5 register start value
    localparam logic [4:0] crc_init = 5'b11111;

    ////////////////////////////////////////////////////////////
    // Parser results
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        cls_none   = 4'h0,
        cls_ack    = 4'h1,
        cls_nak    = 4'h2,
        cls_stl    = 4'h3,
        cls_didx   = 4'h5,
        cls_dparam = 4'h6,
        cls_ddidx  = 4'h7,
        cls_link   = 4'h9,
        cls_error  = 4'hF
    } pkt_class_t;

    typedef struct packed {
        logic [3:0] device_idx;
        logic [3:0] data_idx;
        logic [3:0] sample_rate;
        logic [3:0] filt_up;
        logic [3:0] filt_low;
    } cmd_fields_t;

endpackage

`default_nettype wire
